// ==== ext_rx_defs.svh ====
`ifndef EXT_RX_DEFS_SVH
`define EXT_RX_DEFS_SVH

// External and AXI address widths
`define EXT_ADD_WIDTH    29
`define AXI_ADDR_WIDTH   32

// Read data beat
`define AXI_DATA_WIDTH   64

// Local memory side
`define TCDM_ADD_WIDTH   12

// Transaction IDs, one AXI ID per outstanding burst
`define EXT_TID_WIDTH    4
`define EXT_TID_NUM      (1 << `EXT_TID_WIDTH)

// Burst length in beats minus one
`define AXI_LEN_WIDTH    8

// Stream IDs and command queue
`define TRANS_SID_WIDTH  2
`define CMD_QUEUE_DEPTH  2

`endif

// ==== ext_rx_pkg.sv ====
`default_nettype none

package ext_rx_pkg;

   // Read opcode selects the beat size
   typedef enum logic [1:0] {
      OPC_RD_BYTE  = 2'd0,
      OPC_RD_HALF  = 2'd1,
      OPC_RD_WORD  = 2'd2,
      OPC_RD_DWORD = 2'd3
   } ext_opc_e;

   // AXI size code as log2 of bytes per beat
   typedef logic [2:0] axi_size_t;

   // AR issue FSM
   typedef enum logic {
      ISSUE_IDLE       = 1'b0,
      ISSUE_WAIT_READY = 1'b1
   } issue_state_e;

endpackage

`default_nettype wire

// ==== ext_rx_cmd_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ext_rx_defs.svh"

module ext_rx_cmd_decode (
   input  logic                          clk_i,
   input  logic                          rst_i,

   // External command port
   input  logic                          ext_rx_req_i,
   input  logic [`EXT_ADD_WIDTH-1:0]     ext_rx_add_i,
   input  logic [`TCDM_ADD_WIDTH-1:0]    ext_rx_r_add_i,
   input  ext_rx_pkg::ext_opc_e          ext_rx_opc_i,
   input  logic [`AXI_LEN_WIDTH-1:0]     ext_rx_len_i,
   input  logic [`TRANS_SID_WIDTH-1:0]   ext_rx_sid_i,
   output logic                          ext_rx_gnt_o,

   // Decoded command towards AR issue
   output logic                          dec_valid_o,
   output logic [`EXT_ADD_WIDTH-1:0]     dec_add_o,
   output logic [`TCDM_ADD_WIDTH-1:0]    dec_r_add_o,
   output ext_rx_pkg::axi_size_t         dec_size_o,
   output logic [`AXI_LEN_WIDTH-1:0]     dec_len_o,
   output logic [`TRANS_SID_WIDTH-1:0]   dec_sid_o,
   input  logic                          dec_ready_i
);
   import ext_rx_pkg::*;

   localparam int DEPTH = `CMD_QUEUE_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [`EXT_ADD_WIDTH-1:0]    add_q   [DEPTH];
   logic [`TCDM_ADD_WIDTH-1:0]   r_add_q [DEPTH];
   axi_size_t                    size_q  [DEPTH];
   logic [`AXI_LEN_WIDTH-1:0]    len_q   [DEPTH];
   logic [`TRANS_SID_WIDTH-1:0]  sid_q   [DEPTH];

   logic [PTR_W-1:0]  wr_ptr_q;
   logic [PTR_W-1:0]  rd_ptr_q;
   logic [CNT_W-1:0]  count_q;
   axi_size_t         in_size;
   logic              push;
   logic              pop;

   // Opcode to beat size, done once on entry
   always_comb begin
      case (ext_rx_opc_i)
         OPC_RD_BYTE: in_size = 3'd0;
         OPC_RD_HALF: in_size = 3'd1;
         OPC_RD_WORD: in_size = 3'd2;
         default:     in_size = 3'd3;
      endcase
   end

   assign ext_rx_gnt_o = (count_q != CNT_W'(DEPTH));
   assign dec_valid_o  = (count_q != '0);
   assign push         = ext_rx_req_i && ext_rx_gnt_o;
   assign pop          = dec_valid_o && dec_ready_i;

   //**************************************************************************
   // Pointers and occupancy
   //**************************************************************************
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) begin
         add_q[wr_ptr_q]   <= ext_rx_add_i;
         r_add_q[wr_ptr_q] <= ext_rx_r_add_i;
         size_q[wr_ptr_q]  <= in_size;
         len_q[wr_ptr_q]   <= ext_rx_len_i;
         sid_q[wr_ptr_q]   <= ext_rx_sid_i;
      end
   end

   // Head entry
   assign dec_add_o   = add_q[rd_ptr_q];
   assign dec_r_add_o = r_add_q[rd_ptr_q];
   assign dec_size_o  = size_q[rd_ptr_q];
   assign dec_len_o   = len_q[rd_ptr_q];
   assign dec_sid_o   = sid_q[rd_ptr_q];

   a_count_bound: assert property (@(posedge clk_i) disable iff (rst_i)
      count_q <= CNT_W'(DEPTH));

endmodule

`default_nettype wire

// ==== ext_rx_tid_alloc.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ext_rx_defs.svh"

module ext_rx_tid_alloc (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        alloc_i,
   input  logic                        rel_valid_i,
   input  logic [`EXT_TID_WIDTH-1:0]   rel_tid_i,
   output logic                        tid_valid_o,
   output logic [`EXT_TID_WIDTH-1:0]   tid_o
);
   import ext_rx_pkg::*;

   logic [`EXT_TID_NUM-1:0] busy_q;

   // Lowest free ID wins
   always_comb begin
      tid_o = '0;
      for (int i = `EXT_TID_NUM - 1; i >= 0; i--) begin
         if (!busy_q[i]) begin
            tid_o = `EXT_TID_WIDTH'(i);
         end
      end
   end

   assign tid_valid_o = ~&busy_q;

   // Offered ID is always free, so set and clear never hit the same bit
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         busy_q <= '0;
      end else begin
         if (rel_valid_i) begin
            busy_q[rel_tid_i] <= 1'b0;
         end
         if (alloc_i) begin
            busy_q[tid_o] <= 1'b1;
         end
      end
   end

   // Response side only returns IDs that were handed out
   a_rel_busy: assert property (@(posedge clk_i) disable iff (rst_i)
      rel_valid_i |-> busy_q[rel_tid_i]);

endmodule

`default_nettype wire

// ==== ext_rx_ar_issue.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ext_rx_defs.svh"

module ext_rx_ar_issue (
   input  logic                          clk_i,
   input  logic                          rst_i,

   // Decoded command
   input  logic                          dec_valid_i,
   input  logic [`EXT_ADD_WIDTH-1:0]     dec_add_i,
   input  logic [`TCDM_ADD_WIDTH-1:0]    dec_r_add_i,
   input  ext_rx_pkg::axi_size_t         dec_size_i,
   input  logic [`AXI_LEN_WIDTH-1:0]     dec_len_i,
   input  logic [`TRANS_SID_WIDTH-1:0]   dec_sid_i,
   output logic                          dec_ready_o,

   // ID release from response tracking
   input  logic                          rel_valid_i,
   input  logic [`EXT_TID_WIDTH-1:0]     rel_tid_i,

   // Command record into the response table
   output logic                          rec_we_o,
   output logic [`EXT_TID_WIDTH-1:0]     rec_tid_o,
   output logic [`TCDM_ADD_WIDTH-1:0]    rec_r_add_o,
   output ext_rx_pkg::axi_size_t         rec_size_o,
   output logic [`TRANS_SID_WIDTH-1:0]   rec_sid_o,

   // AXI read address channel
   output logic                          axi_master_ar_valid_o,
   output logic [`AXI_ADDR_WIDTH-1:0]    axi_master_ar_addr_o,
   output logic [`AXI_LEN_WIDTH-1:0]     axi_master_ar_len_o,
   output ext_rx_pkg::axi_size_t         axi_master_ar_size_o,
   output logic [`EXT_TID_WIDTH-1:0]     axi_master_ar_id_o,
   input  logic                          axi_master_ar_ready_i
);
   import ext_rx_pkg::*;

   issue_state_e                 state_q;
   logic                         tid_valid;
   logic [`EXT_TID_WIDTH-1:0]    tid;
   logic                         alloc;

   ext_rx_tid_alloc u_tid_alloc (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .alloc_i     (alloc),
      .rel_valid_i (rel_valid_i),
      .rel_tid_i   (rel_tid_i),
      .tid_valid_o (tid_valid),
      .tid_o       (tid)
   );

   // Accept only when idle and an ID is free
   assign dec_ready_o = (state_q == ISSUE_IDLE) && tid_valid;
   assign alloc       = dec_valid_i && dec_ready_o;

   assign rec_we_o    = alloc;
   assign rec_tid_o   = tid;
   assign rec_r_add_o = dec_r_add_i;
   assign rec_size_o  = dec_size_i;
   assign rec_sid_o   = dec_sid_i;

   assign axi_master_ar_valid_o = (state_q == ISSUE_WAIT_READY);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= ISSUE_IDLE;
      end else begin
         case (state_q)
            ISSUE_IDLE: begin
               if (alloc) begin
                  state_q <= ISSUE_WAIT_READY;
               end
            end
            ISSUE_WAIT_READY: begin
               if (axi_master_ar_ready_i) begin
                  state_q <= ISSUE_IDLE;
               end
            end
            default: state_q <= ISSUE_IDLE;
         endcase
      end
   end

   // AR fields load on acceptance and hold through the wait
   always_ff @(posedge clk_i) begin
      if (alloc) begin
         axi_master_ar_addr_o <= `AXI_ADDR_WIDTH'(dec_add_i);
         axi_master_ar_len_o  <= dec_len_i;
         axi_master_ar_size_o <= dec_size_i;
         axi_master_ar_id_o   <= tid;
      end
   end

   a_ar_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      axi_master_ar_valid_o && !axi_master_ar_ready_i |=>
         axi_master_ar_valid_o && $stable(axi_master_ar_addr_o) &&
         $stable(axi_master_ar_len_o) && $stable(axi_master_ar_size_o) &&
         $stable(axi_master_ar_id_o));

endmodule

`default_nettype wire

// ==== ext_rx_resp_track.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ext_rx_defs.svh"

module ext_rx_resp_track (
   input  logic                          clk_i,
   input  logic                          rst_i,

   // Command record from AR issue
   input  logic                          rec_we_i,
   input  logic [`EXT_TID_WIDTH-1:0]     rec_tid_i,
   input  logic [`TCDM_ADD_WIDTH-1:0]    rec_r_add_i,
   input  ext_rx_pkg::axi_size_t         rec_size_i,
   input  logic [`TRANS_SID_WIDTH-1:0]   rec_sid_i,

   // AXI read data channel
   input  logic                          axi_master_r_valid_i,
   input  logic [`AXI_DATA_WIDTH-1:0]    axi_master_r_data_i,
   input  logic                          axi_master_r_last_i,
   input  logic [`EXT_TID_WIDTH-1:0]     axi_master_r_id_i,
   output logic                          axi_master_r_ready_o,

   // Data port to local memory
   output logic                          rx_data_req_o,
   output logic [`AXI_DATA_WIDTH-1:0]    rx_data_dat_o,
   output logic [`TCDM_ADD_WIDTH-1:0]    rx_data_add_o,
   output logic [`TRANS_SID_WIDTH-1:0]   rx_data_sid_o,
   input  logic                          rx_data_gnt_i,

   // Completion and ID release
   output logic                          rx_synch_req_o,
   output logic [`TRANS_SID_WIDTH-1:0]   rx_synch_sid_o,
   output logic                          rel_valid_o,
   output logic [`EXT_TID_WIDTH-1:0]     rel_tid_o
);
   import ext_rx_pkg::*;

   // Per-ID state, indexed by the AXI ID
   logic [`TCDM_ADD_WIDTH-1:0]   add_tbl  [`EXT_TID_NUM];
   axi_size_t                    size_tbl [`EXT_TID_NUM];
   logic [`TRANS_SID_WIDTH-1:0]  sid_tbl  [`EXT_TID_NUM];
   logic [`EXT_TID_NUM-1:0]      live_q;

   logic                         beat;
   logic                         last_beat;
   logic [`TCDM_ADD_WIDTH-1:0]   step;

   //**************************************************************************
   // Combinational data path
   //**************************************************************************
   assign axi_master_r_ready_o = rx_data_gnt_i;
   assign rx_data_req_o        = axi_master_r_valid_i;
   assign rx_data_dat_o        = axi_master_r_data_i;
   assign rx_data_add_o        = add_tbl[axi_master_r_id_i];
   assign rx_data_sid_o        = sid_tbl[axi_master_r_id_i];

   assign beat      = axi_master_r_valid_i && rx_data_gnt_i;
   assign last_beat = beat && axi_master_r_last_i;
   assign step      = `TCDM_ADD_WIDTH'(1) << size_tbl[axi_master_r_id_i];

   assign rx_synch_req_o = last_beat;
   assign rx_synch_sid_o = sid_tbl[axi_master_r_id_i];
   assign rel_valid_o    = last_beat;
   assign rel_tid_o      = axi_master_r_id_i;

   // Address advances by one beat size, wrapping in local space
   always_ff @(posedge clk_i) begin
      if (beat) begin
         add_tbl[axi_master_r_id_i] <= rx_data_add_o + step;
      end
      if (rec_we_i) begin
         add_tbl[rec_tid_i]  <= rec_r_add_i;
         size_tbl[rec_tid_i] <= rec_size_i;
         sid_tbl[rec_tid_i]  <= rec_sid_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         live_q <= '0;
      end else begin
         if (last_beat) begin
            live_q[axi_master_r_id_i] <= 1'b0;
         end
         if (rec_we_i) begin
            live_q[rec_tid_i] <= 1'b1;
         end
      end
   end

   // Slave only answers IDs we have issued and not yet finished
   a_r_id_live: assert property (@(posedge clk_i) disable iff (rst_i)
      axi_master_r_valid_i |-> live_q[axi_master_r_id_i]);

endmodule

`default_nettype wire

// ==== ext_rx_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ext_rx_defs.svh"

module ext_rx_unit (
   input  logic                          clk_i,
   input  logic                          rst_i,

   // Read command port
   input  logic                          ext_rx_req_i,
   input  logic [`EXT_ADD_WIDTH-1:0]     ext_rx_add_i,
   input  logic [`TCDM_ADD_WIDTH-1:0]    ext_rx_r_add_i,
   input  ext_rx_pkg::ext_opc_e          ext_rx_opc_i,
   input  logic [`AXI_LEN_WIDTH-1:0]     ext_rx_len_i,
   input  logic [`TRANS_SID_WIDTH-1:0]   ext_rx_sid_i,
   output logic                          ext_rx_gnt_o,

   // AXI read address channel
   output logic                          axi_master_ar_valid_o,
   output logic [`AXI_ADDR_WIDTH-1:0]    axi_master_ar_addr_o,
   output logic [`AXI_LEN_WIDTH-1:0]     axi_master_ar_len_o,
   output ext_rx_pkg::axi_size_t         axi_master_ar_size_o,
   output logic [`EXT_TID_WIDTH-1:0]     axi_master_ar_id_o,
   input  logic                          axi_master_ar_ready_i,

   // AXI read data channel
   input  logic                          axi_master_r_valid_i,
   input  logic [`AXI_DATA_WIDTH-1:0]    axi_master_r_data_i,
   input  logic                          axi_master_r_last_i,
   input  logic [`EXT_TID_WIDTH-1:0]     axi_master_r_id_i,
   output logic                          axi_master_r_ready_o,

   // Read data to local memory
   output logic [`AXI_DATA_WIDTH-1:0]    rx_data_dat_o,
   output logic [`TCDM_ADD_WIDTH-1:0]    rx_data_add_o,
   output logic [`TRANS_SID_WIDTH-1:0]   rx_data_sid_o,
   output logic                          rx_data_req_o,
   input  logic                          rx_data_gnt_i,

   // Completion per stream
   output logic                          rx_synch_req_o,
   output logic [`TRANS_SID_WIDTH-1:0]   rx_synch_sid_o
);
   import ext_rx_pkg::*;

   //**************************************************************************
   // Stage to stage signals
   //**************************************************************************
   logic                         dec_valid;
   logic [`EXT_ADD_WIDTH-1:0]    dec_add;
   logic [`TCDM_ADD_WIDTH-1:0]   dec_r_add;
   axi_size_t                    dec_size;
   logic [`AXI_LEN_WIDTH-1:0]    dec_len;
   logic [`TRANS_SID_WIDTH-1:0]  dec_sid;
   logic                         dec_ready;

   logic                         rec_we;
   logic [`EXT_TID_WIDTH-1:0]    rec_tid;
   logic [`TCDM_ADD_WIDTH-1:0]   rec_r_add;
   axi_size_t                    rec_size;
   logic [`TRANS_SID_WIDTH-1:0]  rec_sid;

   logic                         rel_valid;
   logic [`EXT_TID_WIDTH-1:0]    rel_tid;

   // Decode
   ext_rx_cmd_decode u_decode (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .ext_rx_req_i (ext_rx_req_i),
      .ext_rx_add_i (ext_rx_add_i),
      .ext_rx_r_add_i (ext_rx_r_add_i),
      .ext_rx_opc_i (ext_rx_opc_i),
      .ext_rx_len_i (ext_rx_len_i),
      .ext_rx_sid_i (ext_rx_sid_i),
      .ext_rx_gnt_o (ext_rx_gnt_o),
      .dec_valid_o  (dec_valid),
      .dec_add_o    (dec_add),
      .dec_r_add_o  (dec_r_add),
      .dec_size_o   (dec_size),
      .dec_len_o    (dec_len),
      .dec_sid_o    (dec_sid),
      .dec_ready_i  (dec_ready)
   );

   // Execute
   ext_rx_ar_issue u_issue (
      .clk_i                 (clk_i),
      .rst_i                 (rst_i),
      .dec_valid_i           (dec_valid),
      .dec_add_i             (dec_add),
      .dec_r_add_i           (dec_r_add),
      .dec_size_i            (dec_size),
      .dec_len_i             (dec_len),
      .dec_sid_i             (dec_sid),
      .dec_ready_o           (dec_ready),
      .rel_valid_i           (rel_valid),
      .rel_tid_i             (rel_tid),
      .rec_we_o              (rec_we),
      .rec_tid_o             (rec_tid),
      .rec_r_add_o           (rec_r_add),
      .rec_size_o            (rec_size),
      .rec_sid_o             (rec_sid),
      .axi_master_ar_valid_o (axi_master_ar_valid_o),
      .axi_master_ar_addr_o  (axi_master_ar_addr_o),
      .axi_master_ar_len_o   (axi_master_ar_len_o),
      .axi_master_ar_size_o  (axi_master_ar_size_o),
      .axi_master_ar_id_o    (axi_master_ar_id_o),
      .axi_master_ar_ready_i (axi_master_ar_ready_i)
   );

   // Result
   ext_rx_resp_track u_track (
      .clk_i                (clk_i),
      .rst_i                (rst_i),
      .rec_we_i             (rec_we),
      .rec_tid_i            (rec_tid),
      .rec_r_add_i          (rec_r_add),
      .rec_size_i           (rec_size),
      .rec_sid_i            (rec_sid),
      .axi_master_r_valid_i (axi_master_r_valid_i),
      .axi_master_r_data_i  (axi_master_r_data_i),
      .axi_master_r_last_i  (axi_master_r_last_i),
      .axi_master_r_id_i    (axi_master_r_id_i),
      .axi_master_r_ready_o (axi_master_r_ready_o),
      .rx_data_req_o        (rx_data_req_o),
      .rx_data_dat_o        (rx_data_dat_o),
      .rx_data_add_o        (rx_data_add_o),
      .rx_data_sid_o        (rx_data_sid_o),
      .rx_data_gnt_i        (rx_data_gnt_i),
      .rx_synch_req_o       (rx_synch_req_o),
      .rx_synch_sid_o       (rx_synch_sid_o),
      .rel_valid_o          (rel_valid),
      .rel_tid_o            (rel_tid)
   );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
   output logic clk_o
);

   // 100 ns period
   localparam time HALF_PERIOD = 50ns;

   initial begin
      clk_o = 1'b0;
   end

   always begin
      #(HALF_PERIOD);
      clk_o = ~clk_o;
   end

endmodule

`default_nettype wire

// ==== tb_ext_rx_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ext_rx_defs.svh"

module tb_ext_rx_unit;
   import ext_rx_pkg::*;

   localparam int TIMEOUT = 2000;
   localparam int NUM_ID  = `EXT_TID_NUM;

   logic                         clk;
   logic                         rst;

   // Command side
   logic                         cmd_req;
   logic [`EXT_ADD_WIDTH-1:0]    cmd_add;
   logic [`TCDM_ADD_WIDTH-1:0]   cmd_r_add;
   ext_opc_e                     cmd_opc;
   logic [`AXI_LEN_WIDTH-1:0]    cmd_len;
   logic [`TRANS_SID_WIDTH-1:0]  cmd_sid;
   logic                         cmd_gnt;

   // AXI read channels
   logic                         ar_valid;
   logic [`AXI_ADDR_WIDTH-1:0]   ar_addr;
   logic [`AXI_LEN_WIDTH-1:0]    ar_len;
   axi_size_t                    ar_size;
   logic [`EXT_TID_WIDTH-1:0]    ar_id;
   logic                         ar_ready;
   logic                         r_valid;
   logic [`AXI_DATA_WIDTH-1:0]   r_data;
   logic                         r_last;
   logic [`EXT_TID_WIDTH-1:0]    r_id;
   logic                         r_ready;

   // Local data port and completion
   logic [`AXI_DATA_WIDTH-1:0]   rx_dat;
   logic [`TCDM_ADD_WIDTH-1:0]   rx_add;
   logic [`TRANS_SID_WIDTH-1:0]  rx_sid;
   logic                         rx_req;
   logic                         rx_gnt;
   logic                         synch_req;
   logic [`TRANS_SID_WIDTH-1:0]  synch_sid;

   // Traffic knobs in percent
   int req_pct;
   int ar_ready_pct;
   int gnt_pct;
   int rvalid_pct;
   bit resp_en;

   // Reference model: accepted commands not yet seen on AR
   logic [`EXT_ADD_WIDTH-1:0]    q_add   [$];
   logic [`TCDM_ADD_WIDTH-1:0]   q_r_add [$];
   logic [2:0]                   q_size  [$];
   logic [`AXI_LEN_WIDTH-1:0]    q_len   [$];
   logic [`TRANS_SID_WIDTH-1:0]  q_sid   [$];
   logic [NUM_ID-1:0]            model_busy;
   logic [`TCDM_ADD_WIDTH-1:0]   exp_add  [NUM_ID];
   logic [2:0]                   exp_size [NUM_ID];
   logic [`TRANS_SID_WIDTH-1:0]  exp_sid  [NUM_ID];
   int prev_lowest;
   bit prev_full;
   bit prev_ar_valid;
   bit prev_ar_fire;

   // AXI slave pool, one burst per outstanding ID
   bit pool_live  [NUM_ID];
   int pool_len   [NUM_ID];
   int pool_beat  [NUM_ID];
   int pool_issue [NUM_ID];
   int pool_cnt;
   int issue_cnt;
   bit presenting;

   // Counters
   int cmds;
   int ars;
   int beats;
   int exp_beats;
   int synchs;
   int stalls;
   int interleaves;
   int last_id;
   bit last_open;
   bit gnt_seen;
   int errors;
   int tests;
   int failed;

   tb_clk_gen u_clk (
      .clk_o (clk)
   );

   ext_rx_unit UUT (
      .clk_i                 (clk),
      .rst_i                 (rst),
      .ext_rx_req_i          (cmd_req),
      .ext_rx_add_i          (cmd_add),
      .ext_rx_r_add_i        (cmd_r_add),
      .ext_rx_opc_i          (cmd_opc),
      .ext_rx_len_i          (cmd_len),
      .ext_rx_sid_i          (cmd_sid),
      .ext_rx_gnt_o          (cmd_gnt),
      .axi_master_ar_valid_o (ar_valid),
      .axi_master_ar_addr_o  (ar_addr),
      .axi_master_ar_len_o   (ar_len),
      .axi_master_ar_size_o  (ar_size),
      .axi_master_ar_id_o    (ar_id),
      .axi_master_ar_ready_i (ar_ready),
      .axi_master_r_valid_i  (r_valid),
      .axi_master_r_data_i   (r_data),
      .axi_master_r_last_i   (r_last),
      .axi_master_r_id_i     (r_id),
      .axi_master_r_ready_o  (r_ready),
      .rx_data_dat_o         (rx_dat),
      .rx_data_add_o         (rx_add),
      .rx_data_sid_o         (rx_sid),
      .rx_data_req_o         (rx_req),
      .rx_data_gnt_i         (rx_gnt),
      .rx_synch_req_o        (synch_req),
      .rx_synch_sid_o        (synch_sid)
   );

   task automatic compare_value(string sig, logic [63:0] got, logic [63:0] exp);
      assert (got == exp) else begin
         $display("ERROR t=%0t %s got 0x%0h expected 0x%0h", $time, sig, got, exp);
         errors++;
      end
   endtask

   task automatic expect_true(bit cond, string what);
      assert (cond) else begin
         $display("Check failed at %0t: %s", $time, what);
         errors++;
      end
   endtask

   // Lowest free ID, or -1 when all are taken
   function automatic int lowest_free(logic [NUM_ID-1:0] busy);
      for (int i = 0; i < NUM_ID; i++) begin
         if (!busy[i]) begin
            return i;
         end
      end
      return -1;
   endfunction

   function automatic logic [63:0] beat_data(int id, int issue, int beat);
      return {8'(id), 24'(issue), 32'(beat)};
   endfunction

   //**************************************************************************
   // Per-cycle model update and checks, sampled at the falling edge
   //**************************************************************************
   task automatic monitor();
      bit new_ar;
      int lowest;
      int rid;
      logic [`TCDM_ADD_WIDTH-1:0] step;
      gnt_seen = cmd_gnt;
      if (cmd_req && cmd_gnt) begin
         q_add.push_back(cmd_add);
         q_r_add.push_back(cmd_r_add);
         q_size.push_back(3'(cmd_opc));
         q_len.push_back(cmd_len);
         q_sid.push_back(cmd_sid);
         cmds++;
         exp_beats += int'(cmd_len) + 1;
      end
      compare_value("rx_data_req_o", 64'(rx_req), 64'(r_valid));
      compare_value("axi_master_r_ready_o", 64'(r_ready), 64'(rx_gnt));
      compare_value("rx_synch_req_o", 64'(synch_req), 64'(r_valid && rx_gnt && r_last));
      if (synch_req) begin
         synchs++;
      end

      // First cycle of a new AR request
      new_ar = ar_valid && (!prev_ar_valid || prev_ar_fire);
      if (new_ar) begin
         expect_true(q_add.size() > 0, "AR request issued with no accepted command");
         expect_true(!prev_full, "AR request issued while all IDs were busy");
         if (q_add.size() > 0 && !prev_full) begin
            compare_value("axi_master_ar_addr_o", 64'(ar_addr), 64'(q_add[0]));
            compare_value("axi_master_ar_len_o", 64'(ar_len), 64'(q_len[0]));
            compare_value("axi_master_ar_size_o", 64'(ar_size), 64'(q_size[0]));
            compare_value("axi_master_ar_id_o", 64'(ar_id), 64'(prev_lowest));
            exp_add[prev_lowest]  = q_r_add[0];
            exp_size[prev_lowest] = q_size[0];
            exp_sid[prev_lowest]  = q_sid[0];
            model_busy[prev_lowest] = 1'b1;
            void'(q_add.pop_front());
            void'(q_r_add.pop_front());
            void'(q_size.pop_front());
            void'(q_len.pop_front());
            void'(q_sid.pop_front());
         end
         ars++;
      end
      lowest = lowest_free(model_busy);

      // Slave takes the burst on the AR handshake
      if (ar_valid && ar_ready) begin
         pool_live[ar_id]  = 1'b1;
         pool_len[ar_id]   = int'(ar_len);
         pool_beat[ar_id]  = 0;
         pool_issue[ar_id] = issue_cnt;
         issue_cnt++;
         pool_cnt++;
      end
      prev_ar_fire  = ar_valid && ar_ready;
      prev_ar_valid = ar_valid;

      if (r_valid) begin
         rid = int'(r_id);
         compare_value("rx_data_dat_o", rx_dat, r_data);
         compare_value("rx_data_add_o", 64'(rx_add), 64'(exp_add[rid]));
         compare_value("rx_data_sid_o", 64'(rx_sid), 64'(exp_sid[rid]));
         if (!r_ready) begin
            stalls++;
         end else begin
            beats++;
            if (last_open && last_id != rid) begin
               interleaves++;
            end
            last_id   = rid;
            last_open = !r_last;
            step = `TCDM_ADD_WIDTH'(1) << exp_size[rid];
            exp_add[rid] = exp_add[rid] + step;
            pool_beat[rid]++;
            presenting = 1'b0;
            if (r_last) begin
               compare_value("rx_synch_sid_o", 64'(synch_sid), 64'(exp_sid[rid]));
               model_busy[rid] = 1'b0;
               pool_live[rid]  = 1'b0;
               pool_cnt--;
            end
         end
      end
      prev_lowest = lowest;
      prev_full   = (lowest < 0);
   endtask

   // New inputs, 1 ns after the rising edge
   task automatic drive();
      int pick;
      int live_ids [$];
      cmd_req   = (($urandom % 100) < req_pct);
      cmd_add   = `EXT_ADD_WIDTH'($urandom);
      cmd_r_add = `TCDM_ADD_WIDTH'($urandom);
      cmd_opc   = ext_opc_e'(2'($urandom));
      cmd_len   = `AXI_LEN_WIDTH'($urandom % 8);
      cmd_sid   = `TRANS_SID_WIDTH'($urandom);
      ar_ready  = (($urandom % 100) < ar_ready_pct);
      rx_gnt    = (($urandom % 100) < gnt_pct);
      // A presented beat holds until it is taken
      if (!presenting) begin
         r_valid = 1'b0;
         r_last  = 1'b0;
         for (int i = 0; i < NUM_ID; i++) begin
            if (pool_live[i]) begin
               live_ids.push_back(i);
            end
         end
         if (resp_en && live_ids.size() > 0 && (($urandom % 100) < rvalid_pct)) begin
            pick       = live_ids[$urandom % live_ids.size()];
            r_valid    = 1'b1;
            r_id       = `EXT_TID_WIDTH'(pick);
            r_data     = beat_data(pick, pool_issue[pick], pool_beat[pick]);
            r_last     = (pool_beat[pick] == pool_len[pick]);
            presenting = 1'b1;
         end
      end
   endtask

   task automatic step_cycle();
      @(negedge clk);
      monitor();
      @(posedge clk);
      #1;
      drive();
   endtask

   task automatic set_traffic(int req, int arr, int gnt, int rv, bit resp);
      req_pct      = req;
      ar_ready_pct = arr;
      gnt_pct      = gnt;
      rvalid_pct   = rv;
      resp_en      = resp;
   endtask

   task automatic run_commands(int n);
      int target;
      int t;
      target = cmds + n;
      t = 0;
      while (cmds < target && t < TIMEOUT) begin
         step_cycle();
         t++;
      end
      expect_true(cmds >= target, "timeout while sending commands");
   endtask

   // Stop commands and let every burst finish
   task automatic drain();
      int t;
      bit idle;
      set_traffic(0, 70, 70, 70, 1'b1);
      t = 0;
      idle = 1'b0;
      while (!idle && t < TIMEOUT) begin
         step_cycle();
         idle = (q_add.size() == 0) && (pool_cnt == 0) && !ar_valid && !presenting;
         t++;
      end
      expect_true(idle, "timeout while draining outstanding bursts");
   endtask

   task automatic report_test(string name, int errs0);
      tests++;
      if (errors == errs0) begin
         $display("test %0d %s: ok", tests, name);
      end else begin
         failed++;
         $display("test %0d %s: %0d errors", tests, name, errors - errs0);
      end
   endtask

   initial begin
      int errs0;
      int ref_cnt;
      int t;
      bit done;
      void'($urandom(86225));
      rst       = 1'b1;
      cmd_req   = 1'b0;
      cmd_add   = '0;
      cmd_r_add = '0;
      cmd_opc   = OPC_RD_BYTE;
      cmd_len   = '0;
      cmd_sid   = '0;
      ar_ready  = 1'b0;
      r_valid   = 1'b0;
      r_data    = '0;
      r_last    = 1'b0;
      r_id      = '0;
      rx_gnt    = 1'b0;
      set_traffic(0, 0, 0, 0, 1'b0);
      model_busy = '0;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;

      // 1: reset state
      errs0 = errors;
      @(negedge clk);
      compare_value("ext_rx_gnt_o", 64'(cmd_gnt), 64'(1));
      compare_value("axi_master_ar_valid_o", 64'(ar_valid), 64'(0));
      compare_value("rx_data_req_o", 64'(rx_req), 64'(0));
      compare_value("rx_synch_req_o", 64'(synch_req), 64'(0));
      monitor();
      @(posedge clk);
      #1;
      drive();
      report_test("reset state", errs0);

      // 2: AR mapping
      errs0 = errors;
      set_traffic(50, 50, 80, 60, 1'b1);
      run_commands(40);
      drain();
      compare_value("AR request count", 64'(ars), 64'(cmds));
      report_test("AR mapping", errs0);

      // 3: data steering with interleaved IDs
      errs0 = errors;
      set_traffic(60, 90, 50, 90, 1'b1);
      run_commands(40);
      drain();
      compare_value("forwarded beat count", 64'(beats), 64'(exp_beats));
      expect_true(interleaves > 0, "no interleaving of bursts across IDs was seen");
      report_test("data steering", errs0);

      // 4: completion
      errs0 = errors;
      set_traffic(40, 70, 70, 50, 1'b1);
      run_commands(30);
      drain();
      compare_value("rx_synch_req_o pulse count", 64'(synchs), 64'(cmds));
      report_test("completion", errs0);

      // 5: back-pressure on AR, then on the data port
      errs0 = errors;
      set_traffic(100, 0, 50, 50, 1'b1);
      t = 0;
      done = 1'b0;
      while (!done && t < TIMEOUT) begin
         step_cycle();
         done = !gnt_seen;
         t++;
      end
      expect_true(done, "gnt never dropped while ar_ready was held low");
      repeat (10) begin
         step_cycle();
         expect_true(!gnt_seen, "gnt rose again while ar_ready was held low");
      end
      drain();
      compare_value("AR request count", 64'(ars), 64'(cmds));
      set_traffic(30, 100, 0, 100, 1'b1);
      ref_cnt = beats;
      t = stalls;
      repeat (40) step_cycle();
      expect_true(beats == ref_cnt, "a beat was forwarded while rx_data_gnt_i was low");
      expect_true(stalls > t, "no beat was held back by rx_data_gnt_i");
      drain();
      report_test("back-pressure", errs0);

      // 6: all IDs outstanding
      errs0 = errors;
      set_traffic(100, 100, 100, 0, 1'b0);
      t = 0;
      while (pool_cnt < NUM_ID && t < TIMEOUT) begin
         step_cycle();
         t++;
      end
      expect_true(pool_cnt == NUM_ID, "timeout waiting for 16 outstanding bursts");
      ref_cnt = ars;
      repeat (20) step_cycle();
      expect_true(ars == ref_cnt && !ar_valid, "AR request issued with all IDs outstanding");
      set_traffic(100, 100, 100, 100, 1'b1);
      t = 0;
      while (ars == ref_cnt && t < TIMEOUT) begin
         step_cycle();
         t++;
      end
      expect_true(ars > ref_cnt, "issue did not resume after an ID was released");
      drain();
      compare_value("rx_synch_req_o pulse count", 64'(synchs), 64'(cmds));
      report_test("ID exhaustion", errs0);

      $display("tests %0d, failed %0d, errors %0d, commands %0d, beats %0d",
               tests, failed, errors, cmds, beats);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
ext_rx_pkg.sv
ext_rx_cmd_decode.sv
ext_rx_tid_alloc.sv
ext_rx_ar_issue.sv
ext_rx_resp_track.sv
ext_rx_unit.sv
tb_clk_gen.sv
tb_ext_rx_unit.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TB_TOP     := tb_ext_rx_unit
RTL_TOP    := ext_rx_unit
FILELIST   := list.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG   := SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
